//--- design/core_monitor_top.sv
// Core monitor top level joining the trap, data bus and single step checkers to the APB registers
module core_monitor_top import monitor_pkg::*; (
  input  logic      clk,
  input  logic      rst_ni,
  input  wb_event_t wb_i,
  input  csr_save_t csr_save_i,
  input  obi_data_t obi_i,
  input  logic      step_i,
  input  logic      debug_mode_i,
  input  logic      retire_i,
  input  apb_req_t  apb_i,
  output apb_rsp_t  apb_o
);

  logic [N_EXC_CLASSES-1:0] trap_mismatch;
  logic [N_EXC_CLASSES-1:0] trap_captured;
  out_cnt_t                 obi_count;
  logic                     atomic_order;
  logic                     rsp_underflow;
  step_cnt_t                step_count;
  logic                     step_multi;
  event_flags_t             flags;

  trap_epc_checker u_trap_epc_checker (
    .clk        (clk),
    .rst_ni     (rst_ni),
    .wb_i       (wb_i),
    .csr_save_i (csr_save_i),
    .mismatch_o (trap_mismatch),
    .captured_o (trap_captured)
  );

  obi_outstanding_tracker u_obi_outstanding_tracker (
    .clk             (clk),
    .rst_ni          (rst_ni),
    .obi_i           (obi_i),
    .count_o         (obi_count),
    .atomic_order_o  (atomic_order),
    .rsp_underflow_o (rsp_underflow)
  );

  step_retire_counter u_step_retire_counter (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .step_i       (step_i),
    .debug_mode_i (debug_mode_i),
    .retire_i     (retire_i),
    .count_o      (step_count),
    .multi_o      (step_multi)
  );

  // Collect all violation pulses for the status register
  assign flags.mismatch      = trap_mismatch;
  assign flags.atomic_order  = atomic_order;
  assign flags.rsp_underflow = rsp_underflow;
  assign flags.step_multi    = step_multi;

  monitor_apb_regs u_monitor_apb_regs (
    .clk        (clk),
    .rst_ni     (rst_ni),
    .apb_i      (apb_i),
    .apb_o      (apb_o),
    .flags_i    (flags),
    .out_cnt_i  (obi_count),
    .step_cnt_i (step_count),
    .captured_i (trap_captured)
  );

endmodule

//--- design/monitor_apb_regs.sv
// APB register block with sticky write one to clear status flags and read only counters
module monitor_apb_regs import monitor_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_ni,
  input  apb_req_t                 apb_i,
  output apb_rsp_t                 apb_o,
  input  event_flags_t             flags_i,
  input  out_cnt_t                 out_cnt_i,
  input  step_cnt_t                step_cnt_i,
  input  logic [N_EXC_CLASSES-1:0] captured_i
);

  logic                access;
  logic                wr_status;
  logic [STATUS_W-1:0] set_vec;
  logic [STATUS_W-1:0] clr_vec;
  logic [STATUS_W-1:0] status_q;
  word_t               rd_data;

  ////////////////////
  // Access decode
  ////////////////////

  // No wait states, so the access phase is always the last cycle of a transfer
  assign access    = apb_i.psel && apb_i.penable;
  assign wr_status = access && apb_i.pwrite && (apb_i.paddr == REG_STATUS);

  // Place each checker pulse at its status bit
  always_comb begin
    set_vec = '0;
    set_vec[STATUS_MISMATCH_LSB +: N_EXC_CLASSES] = flags_i.mismatch;
    set_vec[STATUS_ATOMIC_ORDER]  = flags_i.atomic_order;
    set_vec[STATUS_RSP_UNDERFLOW] = flags_i.rsp_underflow;
    set_vec[STATUS_STEP_MULTI]    = flags_i.step_multi;
  end

  assign clr_vec = wr_status ? apb_i.pwdata[STATUS_W-1:0] : '0;

  ////////////////////
  // Sticky status
  ////////////////////

  // Set has priority, so a violation in the clearing cycle is never lost
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      status_q <= '0;
    end else begin
      status_q <= (status_q & ~clr_vec) | set_vec;
    end
  end

  ////////////////////
  // Read path
  ////////////////////

  always_comb begin
    case (apb_i.paddr)
      REG_STATUS:       rd_data = word_t'(status_q);
      REG_OUTSTANDING:  rd_data = word_t'(out_cnt_i);
      REG_STEP_RETIRED: rd_data = word_t'(step_cnt_i);
      REG_CAPTURED:     rd_data = word_t'(captured_i);
      default:          rd_data = '0;
    endcase
  end

  // Read data is driven only in the access phase of a read
  assign apb_o.prdata  = (access && !apb_i.pwrite) ? rd_data : '0;
  assign apb_o.pready  = 1'b1;
  assign apb_o.pslverr = 1'b0;

  // The access phase must follow a setup phase of the same transfer
  a_apb_setup_before_access : assert property (
    @(posedge clk) disable iff (!rst_ni)
    $rose(apb_i.penable) |-> (apb_i.psel && $past(apb_i.psel))
  );

endmodule

//--- design/monitor_pkg.sv
// Shared widths, exception cause codes, register map and struct types of the core monitor
package monitor_pkg;

  ////////////////////
  // Widths and basic types
  ////////////////////

  localparam int unsigned XLEN = 32;

  typedef logic [XLEN-1:0] pc_t;
  typedef logic [XLEN-1:0] word_t;
  typedef logic [5:0]      exc_code_t;
  typedef logic [1:0]      out_cnt_t;
  typedef logic [7:0]      step_cnt_t;
  typedef logic [7:0]      apb_addr_t;

  // Synchronous exception cause codes as written to mcause
  localparam exc_code_t EXC_INSTR_BUS_FAULT = 6'd1;
  localparam exc_code_t EXC_ILLEGAL         = 6'd2;
  localparam exc_code_t EXC_BREAKPOINT      = 6'd3;
  localparam exc_code_t EXC_ECALL_M         = 6'd11;

  // Exception classes tracked by the trap PC check, the value is also the flag index
  typedef enum logic [1:0] {
    CLASS_ILLEGAL   = 2'd0,
    CLASS_ECALL     = 2'd1,
    CLASS_EBREAK    = 2'd2,
    CLASS_BUS_FAULT = 2'd3
  } exc_class_e;

  localparam int unsigned N_EXC_CLASSES = 4;

  // Data bus atomic operation field, the top bit marks an atomic transfer
  localparam int unsigned ATOP_W         = 6;
  localparam int unsigned ATOP_VALID_BIT = 5;

  ////////////////////
  // Register map
  ////////////////////

  localparam apb_addr_t REG_STATUS       = 8'h00;
  localparam apb_addr_t REG_OUTSTANDING  = 8'h04;
  localparam apb_addr_t REG_STEP_RETIRED = 8'h08;
  localparam apb_addr_t REG_CAPTURED     = 8'h0C;

  // Bit positions inside the sticky status register
  localparam int unsigned STATUS_MISMATCH_LSB  = 0;
  localparam int unsigned STATUS_ATOMIC_ORDER  = 4;
  localparam int unsigned STATUS_RSP_UNDERFLOW = 5;
  localparam int unsigned STATUS_STEP_MULTI    = 6;
  localparam int unsigned STATUS_W             = 7;

  ////////////////////
  // Observed and bus structs
  ////////////////////

  // Instruction leaving writeback, with the exception reasons it carries
  typedef struct packed {
    logic valid;
    pc_t  pc;
    logic illegal;
    logic ecall;
    logic ebreak;
    logic bus_err;
  } wb_event_t;

  // Cause and mepc being saved by the controller on trap entry
  typedef struct packed {
    logic      save;
    logic      irq;
    exc_code_t code;
    pc_t       mepc;
  } csr_save_t;

  typedef struct packed {
    logic              req;
    logic              gnt;
    logic              rvalid;
    logic [ATOP_W-1:0] atop;
  } obi_data_t;

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    word_t     pwdata;
  } apb_req_t;

  typedef struct packed {
    word_t prdata;
    logic  pready;
    logic  pslverr;
  } apb_rsp_t;

  // One cycle violation pulses from the checkers to the register block
  typedef struct packed {
    logic                     step_multi;
    logic                     rsp_underflow;
    logic                     atomic_order;
    logic [N_EXC_CLASSES-1:0] mismatch;
  } event_flags_t;

endpackage

//--- design/obi_outstanding_tracker.sv
// Data bus outstanding transaction counter with atomic ordering and stray response checks
module obi_outstanding_tracker import monitor_pkg::*; (
  input  logic      clk,
  input  logic      rst_ni,
  input  obi_data_t obi_i,
  output out_cnt_t  count_o,
  output logic      atomic_order_o,
  output logic      rsp_underflow_o
);

  logic     count_up;
  logic     count_down;
  logic     underflow;
  logic     atomic_early;
  out_cnt_t count_q;
  out_cnt_t count_d;
  logic     atomic_order_q;
  logic     rsp_underflow_q;

  // Address phase accepted, or response phase seen
  assign count_up   = obi_i.req && obi_i.gnt;
  assign count_down = obi_i.rvalid;

  // Response with nothing in flight and nothing granted alongside it
  assign underflow = count_down && !count_up && (count_q == '0);

  // Atomics must wait until every earlier transfer has completed
  assign atomic_early = obi_i.req && obi_i.atop[ATOP_VALID_BIT] && (count_q != '0);

  always_comb begin
    count_d = count_q;
    if (count_up && !count_down) begin
      count_d = count_q + 2'd1;
    end else if (count_down && !count_up && !underflow) begin
      count_d = count_q - 2'd1;
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q         <= '0;
      atomic_order_q  <= 1'b0;
      rsp_underflow_q <= 1'b0;
    end else begin
      count_q         <= count_d;
      atomic_order_q  <= atomic_early;
      rsp_underflow_q <= underflow;
    end
  end

  assign count_o         = count_q;
  assign atomic_order_o  = atomic_order_q;
  assign rsp_underflow_o = rsp_underflow_q;

  // The core never has more than three transfers in flight, the counter would wrap
  a_no_count_wrap : assert property (
    @(posedge clk) disable iff (!rst_ni)
    (count_up && !count_down) |-> (count_q != 2'd3)
  );

endmodule

//--- design/step_retire_counter.sv
// Single step retirement counter flagging more than one retired instruction per step
module step_retire_counter import monitor_pkg::*; (
  input  logic      clk,
  input  logic      rst_ni,
  input  logic      step_i,
  input  logic      debug_mode_i,
  input  logic      retire_i,
  output step_cnt_t count_o,
  output logic      multi_o
);

  step_cnt_t count_q;
  logic      multi_q;
  logic      step_retire;

  // Only retirements outside debug mode belong to the step
  assign step_retire = retire_i && step_i && !debug_mode_i;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
      multi_q <= 1'b0;
    end else begin
      multi_q <= 1'b0;
      if (debug_mode_i) begin
        // Back in debug mode, the next step starts from zero
        count_q <= '0;
      end else begin
        if (step_retire && (count_q != '1)) begin
          count_q <= count_q + 8'd1;
        end
        // Any further retirement after the stepped one is a violation
        if (retire_i && (count_q != '0)) begin
          multi_q <= 1'b1;
        end
      end
    end
  end

  assign count_o = count_q;
  assign multi_o = multi_q;

endmodule

//--- design/trap_epc_checker.sv
// Trap PC checker comparing the first faulting PC with the first saved mepc per exception class
module trap_epc_checker import monitor_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_ni,
  input  wb_event_t                wb_i,
  input  csr_save_t                csr_save_i,
  output logic [N_EXC_CLASSES-1:0] mismatch_o,
  output logic [N_EXC_CLASSES-1:0] captured_o
);

  // Class hit from writeback and from the trap save, at most one bit each
  logic [N_EXC_CLASSES-1:0] wb_hit;
  logic [N_EXC_CLASSES-1:0] save_hit;

  // First faulting PC per class
  logic [N_EXC_CLASSES-1:0] exp_found_q;
  pc_t                      exp_pc_q [N_EXC_CLASSES];

  // First saved mepc per class
  logic [N_EXC_CLASSES-1:0] act_found_q;
  pc_t                      act_pc_q [N_EXC_CLASSES];

  logic [N_EXC_CLASSES-1:0] both_found;
  logic [N_EXC_CLASSES-1:0] done_q;
  logic [N_EXC_CLASSES-1:0] pc_diff;
  logic [N_EXC_CLASSES-1:0] mismatch_q;

  ////////////////////
  // Class decode
  ////////////////////

  // Several reasons may be flagged on the same instruction
  // Only the one the core would trap on is considered
  always_comb begin
    wb_hit = '0;
    if (wb_i.valid) begin
      if (wb_i.bus_err) begin
        wb_hit[CLASS_BUS_FAULT] = 1'b1;
      end else if (wb_i.illegal) begin
        wb_hit[CLASS_ILLEGAL] = 1'b1;
      end else if (wb_i.ecall) begin
        wb_hit[CLASS_ECALL] = 1'b1;
      end else if (wb_i.ebreak) begin
        wb_hit[CLASS_EBREAK] = 1'b1;
      end
    end
  end

  // Interrupt entries also save mepc but are ignored here
  always_comb begin
    save_hit = '0;
    if (csr_save_i.save && !csr_save_i.irq) begin
      case (csr_save_i.code)
        EXC_ILLEGAL:         save_hit[CLASS_ILLEGAL]   = 1'b1;
        EXC_ECALL_M:         save_hit[CLASS_ECALL]     = 1'b1;
        EXC_BREAKPOINT:      save_hit[CLASS_EBREAK]    = 1'b1;
        EXC_INSTR_BUS_FAULT: save_hit[CLASS_BUS_FAULT] = 1'b1;
        default:             save_hit                  = '0;
      endcase
    end
  end

  ////////////////////
  // Capture and compare
  ////////////////////

  // Only the first occurrence of each class is kept
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int c = 0; c < N_EXC_CLASSES; c++) begin
        exp_pc_q[c] <= '0;
        act_pc_q[c] <= '0;
      end
    end else begin
      for (int c = 0; c < N_EXC_CLASSES; c++) begin
        if (wb_hit[c] && !exp_found_q[c]) begin
          exp_pc_q[c] <= wb_i.pc;
        end
        if (save_hit[c] && !act_found_q[c]) begin
          act_pc_q[c] <= csr_save_i.mepc;
        end
      end
    end
  end

  always_comb begin
    for (int c = 0; c < N_EXC_CLASSES; c++) begin
      pc_diff[c] = (exp_pc_q[c] != act_pc_q[c]);
    end
  end

  assign both_found = exp_found_q & act_found_q;

  // The compare runs in the cycle after the second half lands, then done_q blocks it
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      exp_found_q <= '0;
      act_found_q <= '0;
      done_q      <= '0;
      mismatch_q  <= '0;
    end else begin
      exp_found_q <= exp_found_q | wb_hit;
      act_found_q <= act_found_q | save_hit;
      done_q      <= done_q | both_found;
      mismatch_q  <= both_found & ~done_q & pc_diff;
    end
  end

  assign mismatch_o = mismatch_q;
  assign captured_o = both_found;

  // A mismatch needs a captured class whose stored PCs still differ
  // Later events of that class must not overwrite the first PCs
  a_mismatch_needs_capture : assert property (
    @(posedge clk) disable iff (!rst_ni)
    (mismatch_o & ~(captured_o & pc_diff)) == '0
  );

endmodule

//--- files.f
design/monitor_pkg.sv
design/trap_epc_checker.sv
design/obi_outstanding_tracker.sv
design/step_retire_counter.sv
design/monitor_apb_regs.sv
design/core_monitor_top.sv
tests/tb_core_monitor.sv

//--- run_sim.sh
#!/bin/sh
# Build the core monitor testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_core_monitor -f files.f -o tb_core_monitor
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_core_monitor > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation executable returned status $run_status"
  exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
  exit 1
fi
exit 0

//--- tests/core_monitor_stimulus.txt
# Columns: op and up to three hex fields. WB pc reasons(1 ill,2 ecall,4 ebreak,8 bus)
# SAVE mepc code irq | BUS bits(1 req,2 gnt,4 rvalid) atop count | STEP step debug retire | WR/RD addr data
RD 00 0
RD 04 0
RD 08 0
RD 0c 0
END reset
WB 100 1
SAVE 100 2 0
RD 00 0
RD 0c 1
END trap_pass
WB 204 3
SAVE 200 b 1
RD 0c 1
END priority
WB 200 2
SAVE 204 b 0
RD 00 2
RD 0c 3
END trap_fail
BUS 3 0 3
BUS 4 0 1
RD 04 2
BUS 1 20 1
RD 00 12
BUS 4 0 3
RD 04 0
RD 00 32
END bus
STEP 1 0 1
STEP 1 0 1
RD 08 2
RD 00 72
STEP 0 1 0
RD 08 0
END step
WR 00 7f
RD 00 0
END clear

//--- tests/tb_core_monitor.sv
// Testbench for the core monitor, driving observed events and APB accesses from a stimulus file
module tb_core_monitor import monitor_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned CLK_PERIOD = 100;
  localparam string       STIM_FILE  = "tests/core_monitor_stimulus.txt";

  logic      clk;
  logic      rst_ni;
  wb_event_t wb;
  csr_save_t csr_save;
  obi_data_t obi;
  logic      step;
  logic      debug_mode;
  logic      retire;
  apb_req_t  apb_req;
  apb_rsp_t  apb_rsp;

  // Stimulus lines without comments, and the bookkeeping of the run
  string lines [$];
  bit    loaded;
  int    errors;
  int    test_errors;
  int    checks;
  int    tests_run;

  core_monitor_top dut0 (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .wb_i         (wb),
    .csr_save_i   (csr_save),
    .obi_i        (obi),
    .step_i       (step),
    .debug_mode_i (debug_mode),
    .retire_i     (retire),
    .apb_i        (apb_req),
    .apb_o        (apb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////
  // Drive and compare
  ////////////////////

  task automatic set_idle();
    wb         = '0;
    csr_save   = '0;
    obi        = '0;
    step       = 1'b0;
    debug_mode = 1'b0;
    retire     = 1'b0;
    apb_req    = '0;
  endtask

  // Every access completes at once and never signals an error
  task automatic check_handshake(input apb_rsp_t rsp, input apb_addr_t addr);
    checks++;
    if (rsp.pready !== 1'b1 || rsp.pslverr !== 1'b0) begin
      $display("error at %0t ns: access to 0x%02h has pready %b pslverr %b, expected 1 0",
               $time, addr, rsp.pready, rsp.pslverr);
      errors++;
      test_errors++;
    end
  endtask

  // Setup cycle, access cycle, then prdata is taken at the falling edge that ends the access
  task automatic apb_access(input logic write, input apb_addr_t addr, input word_t wdata,
                            output word_t rdata);
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;
    @(negedge clk);
    rdata   = apb_rsp.prdata;
    check_handshake(apb_rsp, addr);
    apb_req = '0;
  endtask

  task automatic check_word(input word_t got, input word_t exp, input apb_addr_t addr);
    checks++;
    if (got !== exp) begin
      $display("error at %0t ns: read of 0x%02h returned 0x%08h, expected 0x%08h",
               $time, addr, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_count(input out_cnt_t got, input out_cnt_t exp);
    checks++;
    if (got !== exp) begin
      $display("error at %0t ns: outstanding count is %0d, expected %0d", $time, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  ////////////////////
  // Watchdog
  ////////////////////

  // A stimulus line takes a few cycles, four per line plus a margin covers the whole file
  initial begin : watchdog
    wait (loaded);
    repeat (lines.size() * 4 + 100) @(posedge clk);
    $display("Timeout: the stimulus did not finish within %0d cycles", lines.size() * 4 + 100);
    $display("Simulation FAILED");
    $finish;
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin : main
    int    fd;
    int    n;
    string line;
    string op;
    string name;
    word_t a;
    word_t b;
    word_t c;
    word_t rdata;
    set_idle();
    rst_ni = 1'b0;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file %s", STIM_FILE);
      $display("Simulation FAILED");
      $finish;
    end else begin
      // Comment lines start with a hash and blank lines are skipped
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 1 && line[0] != "#") begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
      loaded = 1'b1;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_ni = 1'b1;
      foreach (lines[i]) begin
        a = '0;
        b = '0;
        c = '0;
        n = $sscanf(lines[i], "%s %h %h %h", op, a, b, c);
        if (op == "WB") begin
          @(negedge clk);
          wb.valid   = 1'b1;
          wb.pc      = a;
          wb.illegal = b[0];
          wb.ecall   = b[1];
          wb.ebreak  = b[2];
          wb.bus_err = b[3];
          @(negedge clk);
          set_idle();
        end else if (op == "SAVE") begin
          @(negedge clk);
          csr_save.save = 1'b1;
          csr_save.mepc = a;
          csr_save.code = b[5:0];
          csr_save.irq  = c[0];
          @(negedge clk);
          set_idle();
        end else if (op == "BUS") begin
          // Back to back bus cycles, c gives how many
          repeat (c) begin
            @(negedge clk);
            obi.req    = a[0];
            obi.gnt    = a[1];
            obi.rvalid = a[2];
            obi.atop   = b[ATOP_W-1:0];
          end
          @(negedge clk);
          set_idle();
        end else if (op == "STEP") begin
          @(negedge clk);
          step       = a[0];
          debug_mode = b[0];
          retire     = c[0];
          @(negedge clk);
          set_idle();
        end else if (op == "WR") begin
          apb_access(1'b1, apb_addr_t'(a), b, rdata);
        end else if (op == "RD") begin
          apb_access(1'b0, apb_addr_t'(a), '0, rdata);
          check_word(rdata, b, apb_addr_t'(a));
          if (apb_addr_t'(a) == REG_OUTSTANDING) begin
            check_count(out_cnt_t'(rdata), out_cnt_t'(b));
          end
        end else if (op == "END") begin
          n = $sscanf(lines[i], "%s %s", op, name);
          $display("test %0s %0s with %0d errors", name,
                   (test_errors == 0) ? "passed" : "failed", test_errors);
          tests_run++;
          test_errors = 0;
        end else begin
          $display("Unknown operation in stimulus line: %0s", lines[i]);
          errors++;
        end
      end
      $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
      if (errors == 0) begin
        $display("Simulation PASSED");
      end else begin
        $display("Simulation FAILED");
      end
      $finish;
    end
  end

endmodule
